// File: design/microrocPkg.sv
package microrocPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Host command interface
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    CmdNop        = 3'd0,  // Ignored
    CmdLoadConfig = 3'd1,  // Serial load of scConfig
    CmdStartAcq   = 3'd2,  // arg holds acquisition window in Clk cycles
    CmdSetChannel = 3'd3,  // arg[0] selects chip 2
    CmdSetPower   = 3'd4   // arg[0] enables power pulsing
  } hostOpcode_t;

  typedef struct packed {
    logic        valid;
    hostOpcode_t opcode;
    logic [15:0] arg;
  } hostCmd_t;

  // Decode to sequencer
  typedef struct packed {
    logic        start;         // One cycle pulse
    logic [15:0] acqTime;       // START_ACQ length
    logic        channelSel;    // 0 for chip 1
    logic        powerPulsing;  // Drop PWR_ON between acquisitions
  } acqCtrl_t;

  ////////////////////////////////////////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    DaqIdle, DaqPowerUp, DaqAcquire, DaqReadStart, DaqReadWait, DaqDone
  } daqState_t;

  typedef enum logic [1:0] {ScIdle, ScReset, ScShift, ScDone} scState_t;

  // Word towards the external FIFO
  typedef struct packed {
    logic        valid;
    logic [15:0] data;
  } fifoWord_t;

endpackage

// File: design/commandDecode.sv
`timescale 1ns/1ps

module commandDecode (
  input  logic                  Clk,
  input  logic                  rstN,
  input  microrocPkg::hostCmd_t hostCmd,    // Sampled on every rising edge
  input  logic                  scBusy,     // Slow control load running
  input  logic                  daqBusy,    // Acquisition running
  output logic                  cmdAccept,
  output logic                  cmdReject,
  output logic                  loadStart,  // Pulse to slowControlLoad
  output microrocPkg::acqCtrl_t acqCtrl
);
  import microrocPkg::*;

  logic busy;
  logic isCmd;
  logic known;

  // Start pulse still in flight counts as busy too
  assign busy  = scBusy | daqBusy | loadStart | acqCtrl.start;
  assign isCmd = hostCmd.valid && (hostCmd.opcode != CmdNop);

  // Opcode check
  always_comb begin
    case (hostCmd.opcode)
      CmdLoadConfig, CmdStartAcq, CmdSetChannel, CmdSetPower: known = 1'b1;
      default: known = 1'b0;
    endcase
  end

  always_ff @(posedge Clk) begin
    if (!rstN) begin
      cmdAccept <= 1'b0;
      cmdReject <= 1'b0;
      loadStart <= 1'b0;
      acqCtrl   <= '0;  // Chip 1 and no power pulsing
    end else begin
      cmdAccept     <= 1'b0;  // Default all pulses low
      cmdReject     <= 1'b0;
      loadStart     <= 1'b0;
      acqCtrl.start <= 1'b0;
      if (isCmd) begin
        if (busy || !known) begin
          cmdReject <= 1'b1;  // Settings untouched
        end else begin
          cmdAccept <= 1'b1;
          case (hostCmd.opcode)
            CmdLoadConfig: loadStart <= 1'b1;
            CmdStartAcq: begin
              acqCtrl.start   <= 1'b1;
              acqCtrl.acqTime <= hostCmd.arg;
            end
            CmdSetChannel: acqCtrl.channelSel   <= hostCmd.arg[0];  // Kept until next set
            CmdSetPower:   acqCtrl.powerPulsing <= hostCmd.arg[0];
            default: ;
          endcase
        end
      end
    end
  end

endmodule

// File: design/slowControlLoad.sv
`timescale 1ns/1ps

module slowControlLoad #(
  parameter int ScBits     = 64,  // Configuration length
  parameter int SlowDivide = 2    // Clk cycles per SR_CK half period
) (
  input  logic              Clk,
  input  logic              rstN,
  input  logic              loadStart,
  input  logic [ScBits-1:0] scConfig,  // MSB goes out first
  output logic              SR_RSTB,
  output logic              SR_CK,
  output logic              SR_IN,
  output logic              scBusy,
  output logic              loadDone
);
  import microrocPkg::*;

  localparam int DivW = $clog2(SlowDivide + 1);
  localparam int BitW = $clog2(ScBits + 1);

  scState_t          state;
  logic [ScBits-1:0] shiftReg;
  logic [DivW-1:0]   divCnt;
  logic [BitW-1:0]   bitCnt;   // Bits already clocked out
  logic              tick;     // End of one SR_CK half period
  logic              rstHalf;  // Second half of the SR_RSTB period

  assign tick   = (divCnt == DivW'(SlowDivide - 1));
  assign scBusy = (state != ScIdle);

  // Slow clock divider, parked while idle
  always_ff @(posedge Clk) begin
    if (!rstN) begin
      divCnt <= '0;
    end else if (state == ScIdle || tick) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  // Config snapshot and shift on SR_CK falling
  always_ff @(posedge Clk) begin
    if (state == ScIdle && loadStart) begin
      shiftReg <= scConfig;
    end else if (state == ScShift && tick && SR_CK) begin
      shiftReg <= {shiftReg[ScBits-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Load sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (!rstN) begin
      state    <= ScIdle;
      SR_RSTB  <= 1'b0;
      SR_CK    <= 1'b0;
      SR_IN    <= 1'b0;
      bitCnt   <= '0;
      rstHalf  <= 1'b0;
      loadDone <= 1'b0;
    end else begin
      loadDone <= 1'b0;
      case (state)
        ScIdle: begin
          if (loadStart) begin
            state   <= ScReset;
            SR_RSTB <= 1'b0;  // Clear the ASIC register first
            rstHalf <= 1'b0;
          end
        end
        ScReset: begin
          if (tick) begin
            rstHalf <= ~rstHalf;
            if (rstHalf) begin  // Full SR_CK period elapsed
              SR_RSTB <= 1'b1;
              SR_IN   <= shiftReg[ScBits-1];  // First bit ahead of first rise
              bitCnt  <= '0;
              state   <= ScShift;
            end
          end
        end
        ScShift: begin
          if (tick) begin
            SR_CK <= ~SR_CK;
            if (SR_CK) begin  // Falling edge, SR_IN may move
              if (bitCnt == BitW'(ScBits - 1)) begin
                state    <= ScDone;
                loadDone <= 1'b1;
                SR_IN    <= 1'b0;
              end else begin
                bitCnt <= bitCnt + 1'b1;
                SR_IN  <= shiftReg[ScBits-2];
              end
            end
          end
        end
        ScDone: state <= ScIdle;  // loadDone high here
        default: state <= ScIdle;
      endcase
    end
  end

endmodule

// File: design/daqSequencer.sv
`timescale 1ns/1ps

module daqSequencer (
  input  logic                  Clk,
  input  logic                  rstN,
  input  microrocPkg::acqCtrl_t acqCtrl,
  input  logic                  END_READOUT1,
  input  logic                  END_READOUT2,
  output logic                  START_ACQ,
  output logic                  RESET_B,
  output logic                  START_READOUT1,
  output logic                  START_READOUT2,
  output logic                  PWR_ON_A,
  output logic                  PWR_ON_D,
  output logic                  PWR_ON_DAC,
  output logic                  PWR_ON_ADC,
  output logic                  daqBusy,
  output logic                  onceEnd
);
  import microrocPkg::*;

  daqState_t   state;
  logic [15:0] acqCnt;      // Remaining START_ACQ cycles
  logic        pwrGate;     // Power requested by the sequence
  logic        endReadout;  // From selected chip
  logic        powerOn;

  // Redundancy select, settings frozen while busy
  assign endReadout = acqCtrl.channelSel ? END_READOUT2 : END_READOUT1;

  ////////////////////////////////////////////////////////////////////////////
  // Acquisition FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (!rstN) begin
      state   <= DaqIdle;
      acqCnt  <= '0;
      pwrGate <= 1'b0;
    end else begin
      case (state)
        DaqIdle: begin
          if (acqCtrl.start) begin
            state   <= DaqPowerUp;
            pwrGate <= 1'b1;  // PWR_ON up in DaqPowerUp
            acqCnt  <= acqCtrl.acqTime;
          end
        end
        DaqPowerUp: begin
          // Zero window skips START_ACQ
          state <= (acqCnt == '0) ? DaqReadStart : DaqAcquire;
        end
        DaqAcquire: begin
          acqCnt <= acqCnt - 16'd1;
          if (acqCnt == 16'd1) begin
            state <= DaqReadStart;
          end
        end
        DaqReadStart: state <= DaqReadWait;  // Single pulse
        DaqReadWait: begin
          if (endReadout) begin
            state <= DaqDone;
          end
        end
        DaqDone: begin
          pwrGate <= 1'b0;
          state   <= DaqIdle;
        end
        default: state <= DaqIdle;
      endcase
    end
  end

  // Pin decode from state
  assign START_ACQ      = (state == DaqAcquire);
  assign RESET_B        = (state != DaqPowerUp);  // Low one cycle
  assign START_READOUT1 = (state == DaqReadStart) && !acqCtrl.channelSel;
  assign START_READOUT2 = (state == DaqReadStart) && acqCtrl.channelSel;
  assign onceEnd        = (state == DaqDone);
  assign daqBusy        = (state != DaqIdle);

  // Without power pulsing the chip stays powered
  assign powerOn    = pwrGate | ~acqCtrl.powerPulsing;
  assign PWR_ON_A   = powerOn;
  assign PWR_ON_D   = powerOn;
  assign PWR_ON_DAC = powerOn;
  assign PWR_ON_ADC = powerOn;

endmodule

// File: design/ramReadout.sv
`timescale 1ns/1ps

module ramReadout #(
  parameter int CreditMax = 4  // Initial and maximum credits
) (
  input  logic                   Clk,
  input  logic                   rstN,
  input  logic                   channelSel,    // 0 for chip 1
  input  logic                   DOUT1B,        // Active low data
  input  logic                   DOUT2B,
  input  logic                   TRANSMITON1B,  // Active low bit strobe
  input  logic                   TRANSMITON2B,
  input  logic                   fifoCredit,    // One credit back per pulse
  output microrocPkg::fifoWord_t fifoOut,
  output logic                   overrun        // Sticky
);
  import microrocPkg::*;

  localparam int CreditW = $clog2(CreditMax + 1);

  logic               dout;
  logic               transmitOn;
  logic [15:0]        shiftReg;
  logic [3:0]         bitCnt;
  fifoWord_t          newWord;     // Complete word this cycle
  logic [15:0]        buffer [4];
  logic [1:0]         wrPtr;
  logic [1:0]         rdPtr;
  logic [2:0]         count;
  logic [CreditW-1:0] credits;
  logic               full;
  logic               push;
  logic               pop;

  // Chip select
  assign dout       = channelSel ? DOUT2B : DOUT1B;
  assign transmitOn = !(channelSel ? TRANSMITON2B : TRANSMITON1B);

  assign newWord.valid = transmitOn && (bitCnt == 4'd15);
  assign newWord.data  = {shiftReg[14:0], ~dout};  // MSB first

  assign full = (count == 3'd4);
  assign push = newWord.valid && !full;
  assign pop  = (count != 3'd0) && (credits != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Deserializer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (transmitOn) begin
      shiftReg <= newWord.data;
    end
  end

  always_ff @(posedge Clk) begin
    if (!rstN) begin
      bitCnt <= '0;
    end else if (transmitOn) begin
      bitCnt <= bitCnt + 4'd1;  // Wraps after each word
    end
  end

  // Four entry buffer
  always_ff @(posedge Clk) begin
    if (push) begin
      buffer[wrPtr] <= newWord.data;
    end
  end

  always_ff @(posedge Clk) begin
    if (!rstN) begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      count   <= '0;
      overrun <= 1'b0;
      credits <= CreditW'(CreditMax);
    end else begin
      if (push) wrPtr <= wrPtr + 2'd1;
      if (pop)  rdPtr <= rdPtr + 2'd1;
      count <= count + {2'b0, push} - {2'b0, pop};
      if (newWord.valid && full) begin
        overrun <= 1'b1;  // Word lost
      end
      case ({pop, fifoCredit})
        2'b10: credits <= credits - 1'b1;
        2'b01: if (credits != CreditW'(CreditMax)) credits <= credits + 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  // Output stage
  always_ff @(posedge Clk) begin
    if (!rstN) begin
      fifoOut.valid <= 1'b0;
    end else begin
      fifoOut.valid <= pop;
    end
  end

  always_ff @(posedge Clk) begin
    if (pop) begin
      fifoOut.data <= buffer[rdPtr];
    end
  end

endmodule

// File: design/microrocControl.sv
`timescale 1ns/1ps

module microrocControl #(
  parameter int ScBits     = 64,
  parameter int SlowDivide = 2,
  parameter int CreditMax  = 4
) (
  input  logic                   Clk,
  input  logic                   rstN,
  // Host side
  input  microrocPkg::hostCmd_t  hostCmd,
  input  logic [ScBits-1:0]      scConfig,
  output logic                   cmdAccept,
  output logic                   cmdReject,
  output logic                   loadDone,
  output logic                   onceEnd,
  output logic                   overrun,
  // External FIFO
  output microrocPkg::fifoWord_t fifoOut,
  input  logic                   fifoCredit,
  // Slow control pins
  output logic                   SR_RSTB,
  output logic                   SR_CK,
  output logic                   SR_IN,
  // Power pulsing pins
  output logic                   PWR_ON_A,
  output logic                   PWR_ON_D,
  output logic                   PWR_ON_DAC,
  output logic                   PWR_ON_ADC,
  // Acquisition pins
  output logic                   START_ACQ,
  output logic                   RESET_B,
  output logic                   START_READOUT1,
  output logic                   START_READOUT2,
  input  logic                   END_READOUT1,
  input  logic                   END_READOUT2,
  // RAM readout pins
  input  logic                   DOUT1B,
  input  logic                   DOUT2B,
  input  logic                   TRANSMITON1B,
  input  logic                   TRANSMITON2B
);
  import microrocPkg::*;

  logic     scBusy;
  logic     daqBusy;
  logic     loadStart;
  acqCtrl_t acqCtrl;

  commandDecode i_commandDecode (
    .Clk      (Clk),
    .rstN     (rstN),
    .hostCmd  (hostCmd),
    .scBusy   (scBusy),
    .daqBusy  (daqBusy),
    .cmdAccept(cmdAccept),
    .cmdReject(cmdReject),
    .loadStart(loadStart),
    .acqCtrl  (acqCtrl)
  );

  slowControlLoad #(
    .ScBits    (ScBits),
    .SlowDivide(SlowDivide)
  ) i_slowControlLoad (
    .Clk      (Clk),
    .rstN     (rstN),
    .loadStart(loadStart),
    .scConfig (scConfig),
    .SR_RSTB  (SR_RSTB),
    .SR_CK    (SR_CK),
    .SR_IN    (SR_IN),
    .scBusy   (scBusy),
    .loadDone (loadDone)
  );

  daqSequencer i_daqSequencer (
    .Clk           (Clk),
    .rstN          (rstN),
    .acqCtrl       (acqCtrl),
    .END_READOUT1  (END_READOUT1),
    .END_READOUT2  (END_READOUT2),
    .START_ACQ     (START_ACQ),
    .RESET_B       (RESET_B),
    .START_READOUT1(START_READOUT1),
    .START_READOUT2(START_READOUT2),
    .PWR_ON_A      (PWR_ON_A),
    .PWR_ON_D      (PWR_ON_D),
    .PWR_ON_DAC    (PWR_ON_DAC),
    .PWR_ON_ADC    (PWR_ON_ADC),
    .daqBusy       (daqBusy),
    .onceEnd       (onceEnd)
  );

  ramReadout #(
    .CreditMax(CreditMax)
  ) i_ramReadout (
    .Clk         (Clk),
    .rstN        (rstN),
    .channelSel  (acqCtrl.channelSel),  // Same chip as the sequencer
    .DOUT1B      (DOUT1B),
    .DOUT2B      (DOUT2B),
    .TRANSMITON1B(TRANSMITON1B),
    .TRANSMITON2B(TRANSMITON2B),
    .fifoCredit  (fifoCredit),
    .fifoOut     (fifoOut),
    .overrun     (overrun)
  );

endmodule

// File: verif/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter real HalfPeriod = 2.0  // 4 ns period
) (
  output logic Clk
);

  initial begin
    Clk = 1'b0;
    forever #(HalfPeriod) Clk = ~Clk;
  end

endmodule

// File: verif/microrocControlAssertions.sv
`timescale 1ns/1ps

module microrocControlAssertions #(
  parameter int CreditMax = 4
) (
  input logic                   Clk,
  input logic                   rstN,
  input logic                   SR_RSTB,
  input logic                   SR_CK,
  input logic                   SR_IN,
  input logic                   loadDone,
  input logic                   START_ACQ,
  input logic                   RESET_B,
  input logic                   START_READOUT1,
  input logic                   START_READOUT2,
  input logic                   onceEnd,
  input logic                   overrun,
  input logic                   fifoCredit,
  input microrocPkg::fifoWord_t fifoOut
);
  import microrocPkg::*;

  int errCount = 0;  // Read by the testbench top
  int creditModel;   // CreditMax plus returned minus taken

  always @(posedge Clk) begin
    if (!rstN) creditModel <= CreditMax;
    else creditModel <= creditModel + int'(fifoCredit) - int'(fifoOut.valid);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Slow control stream
  ////////////////////////////////////////////////////////////////////////////

  srInStable: assert property (@(posedge Clk) disable iff (!rstN)
    $rose(SR_CK) |-> $stable(SR_IN))
    else begin
      $error("SR_IN moved at an SR_CK rising edge");
      errCount++;
    end

  noClockInReset: assert property (@(posedge Clk) disable iff (!rstN)
    !SR_RSTB |-> !SR_CK)
    else begin
      $error("SR_CK toggled while SR_RSTB low");
      errCount++;
    end

  loadDonePulse: assert property (@(posedge Clk) disable iff (!rstN)
    loadDone |=> !loadDone)
    else begin
      $error("loadDone longer than one cycle");
      errCount++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // Acquisition pins
  ////////////////////////////////////////////////////////////////////////////

  acqAfterPowerUp: assert property (@(posedge Clk) disable iff (!rstN)
    $rose(START_ACQ) |-> $past(!RESET_B))
    else begin
      $error("START_ACQ not one cycle after power up");
      errCount++;
    end

  readoutPulse: assert property (@(posedge Clk) disable iff (!rstN)
    (START_READOUT1 || START_READOUT2) |=> !(START_READOUT1 || START_READOUT2))
    else begin
      $error("START_READOUT longer than one cycle");
      errCount++;
    end

  onceEndPulse: assert property (@(posedge Clk) disable iff (!rstN)
    onceEnd |=> !onceEnd)
    else begin
      $error("onceEnd longer than one cycle");
      errCount++;
    end

  // FIFO side
  creditUse: assert property (@(posedge Clk) disable iff (!rstN)
    fifoOut.valid |-> (creditModel > 0))
    else begin
      $error("fifoOut valid with no credit left");
      errCount++;
    end

  noOverrun: assert property (@(posedge Clk) disable iff (!rstN)
    !overrun)
    else begin
      $error("Readout buffer overrun");
      errCount++;
    end

endmodule

bind microrocControl microrocControlAssertions #(.CreditMax(CreditMax)) u_assertions (.*);

// File: verif/microrocControlTb.sv
`timescale 1ns/1ps

module microrocControlTb;
  import microrocPkg::*;

  localparam int ScBits     = 64;
  localparam int SlowDivide = 2;
  localparam int CreditMax  = 4;
  localparam int MaxWords   = 8;
  localparam int LoadLen    = 2 * SlowDivide * (ScBits + 2) + 40;
  localparam int AcqLen     = 40 + MaxWords * 17 + 80;
  localparam int CycleLimit = 2 * LoadLen + 3 * AcqLen + 300;  // Whole run

  logic Clk;
  logic rstN;
  hostCmd_t hostCmd;
  logic [ScBits-1:0] scConfig;
  logic cmdAccept, cmdReject, loadDone, onceEnd, overrun;
  fifoWord_t fifoOut;
  logic fifoCredit = 1'b0;
  logic SR_RSTB, SR_CK, SR_IN;
  logic PWR_ON_A, PWR_ON_D, PWR_ON_DAC, PWR_ON_ADC;
  logic START_ACQ, RESET_B, START_READOUT1, START_READOUT2;
  logic END_READOUT1, END_READOUT2, DOUT1B, DOUT2B, TRANSMITON1B, TRANSMITON2B;

  logic [15:0] expQ[$];   // Words from the selected chip
  logic        srBits[$];
  int cycle = 0;
  int wordsToSend = 0;
  int owed = 0;           // Credits not yet returned
  bit holdCredits = 0;
  bit capturing = 0;
  bit checkPowerHigh = 0;
  bit srCkPrev = 0, pwrPrev = 0, acqPrev = 0;
  int loadDoneCnt, acqHighCnt, sro1Cnt, sro2Cnt, onceCnt, pwrRiseCycle, acqRiseCycle;

  tbClock i_tbClock (.Clk(Clk));

  microrocControl #(
    .ScBits(ScBits), .SlowDivide(SlowDivide), .CreditMax(CreditMax)
  ) i_microrocControl (.*);

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors, run limit and credit return
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge Clk) begin
    cycle++;
    if (cycle > CycleLimit) failNow("Timeout, run exceeded its cycle limit");
  end

  always @(negedge Clk) begin
    if (rstN) begin
      if (capturing && SR_CK && !srCkPrev) srBits.push_back(SR_IN);  // SR_CK rise
      if (loadDone) loadDoneCnt++;
      if (START_ACQ) acqHighCnt++;
      if (START_READOUT1) sro1Cnt++;
      if (START_READOUT2) sro2Cnt++;
      if (onceEnd) onceCnt++;
      if (PWR_ON_A && !pwrPrev) pwrRiseCycle = cycle;
      if (START_ACQ && !acqPrev) acqRiseCycle = cycle;
      if (checkPowerHigh)
        assert ({PWR_ON_A, PWR_ON_D, PWR_ON_DAC, PWR_ON_ADC} == 4'hf)
          else reportMismatch("PWR_ON", {PWR_ON_A, PWR_ON_D, PWR_ON_DAC, PWR_ON_ADC}, 4'hf);
      if (fifoOut.valid) begin
        if (expQ.size() == 0) failNow("Word on fifoOut while none was expected");
        else assert (fifoOut.data == expQ[0])
          else reportMismatch("fifoOut.data", fifoOut.data, expQ[0]);
        if (expQ.size() != 0) void'(expQ.pop_front());
      end
      // Bound checks report here
      if (i_microrocControl.u_assertions.errCount != 0)
        failNow("A bound concurrent assertion failed");
    end
    srCkPrev = SR_CK;
    pwrPrev  = PWR_ON_A;
    acqPrev  = START_ACQ;
  end

  // Consumer returns one credit per word after a random gap
  always @(posedge Clk) begin
    if (!rstN) begin
      owed = 0;
      fifoCredit <= 1'b0;
    end else begin
      if (fifoOut.valid) owed++;
      if (owed > 0 && !holdCredits && ($urandom % 3) != 0) begin
        fifoCredit <= 1'b1;
        owed--;
      end else begin
        fifoCredit <= 1'b0;
      end
    end
  end

  // ASIC model with the selected chip sending words and the other one noise
  initial begin
    logic [15:0] word, noise, strobe;
    bit sel;
    DOUT1B = 1'b1;
    DOUT2B = 1'b1;
    TRANSMITON1B = 1'b1;
    TRANSMITON2B = 1'b1;
    END_READOUT1 = 1'b0;
    END_READOUT2 = 1'b0;
    forever begin
      @(posedge Clk);
      if (START_READOUT1 || START_READOUT2) begin
        sel = START_READOUT2;
        for (int w = 0; w < wordsToSend; w++) begin
          word   = 16'($urandom);
          noise  = 16'($urandom);
          strobe = 16'($urandom);
          expQ.push_back(word);
          for (int b = 15; b >= 0; b--) begin
            DOUT1B <= sel ? ~noise[b] : ~word[b];
            DOUT2B <= sel ? ~word[b] : ~noise[b];
            TRANSMITON1B <= sel ? strobe[b] : 1'b0;  // Unselected chip strobes at random
            TRANSMITON2B <= sel ? 1'b0 : strobe[b];
            @(posedge Clk);
          end
          TRANSMITON1B <= 1'b1;
          TRANSMITON2B <= 1'b1;
          @(posedge Clk);
        end
        if (sel) END_READOUT2 <= 1'b1;
        else END_READOUT1 <= 1'b1;
        @(posedge Clk);
        END_READOUT1 <= 1'b0;
        END_READOUT2 <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic sendCmd(input hostOpcode_t op, input logic [15:0] arg, input bit expAccept);
    @(posedge Clk);
    hostCmd.valid  <= 1'b1;
    hostCmd.opcode <= op;
    hostCmd.arg    <= arg;
    @(posedge Clk);
    hostCmd <= '0;
    @(negedge Clk);
    assert (cmdAccept == expAccept) else reportMismatch("cmdAccept", cmdAccept, expAccept);
    assert (cmdReject == !expAccept) else reportMismatch("cmdReject", cmdReject, !expAccept);
  endtask

  task automatic loadConfig();
    logic [ScBits-1:0] cfg;
    int lowCnt;
    cfg = {$urandom, $urandom};
    @(posedge Clk);
    scConfig <= cfg;
    srBits.delete();
    loadDoneCnt = 0;
    capturing = 1;
    sendCmd(CmdLoadConfig, 16'h0, 1);
    lowCnt = 0;
    @(negedge Clk);
    while (!SR_RSTB) begin
      lowCnt++;
      @(negedge Clk);
    end
    assert (lowCnt == 2 * SlowDivide)
      else reportMismatch("SR_RSTB low cycles", lowCnt, 2 * SlowDivide);
    sendCmd(CmdSetPower, 16'h1, 0);  // Rejected while loading
    while (!loadDone) @(negedge Clk);
    repeat (3) @(negedge Clk);
    capturing = 0;
    // Power pulsing still off
    assert ({PWR_ON_A, PWR_ON_D, PWR_ON_DAC, PWR_ON_ADC} == 4'hf)
      else reportMismatch("PWR_ON after load", {PWR_ON_A, PWR_ON_D, PWR_ON_DAC, PWR_ON_ADC},
        4'hf);
    assert (srBits.size() == ScBits) else reportMismatch("SR bit count", srBits.size(), ScBits);
    foreach (srBits[i])
      assert (srBits[i] == cfg[ScBits-1-i])
        else reportMismatch("SR_IN", srBits[i], cfg[ScBits-1-i]);
    assert (loadDoneCnt == 1) else reportMismatch("loadDone pulses", loadDoneCnt, 1);
  endtask

  task automatic runAcq(input logic [15:0] n, input bit chan, input bit pulsing,
                        input int words, input bit hold);
    sendCmd(CmdSetChannel, {15'h0, chan}, 1);
    sendCmd(CmdSetPower, {15'h0, pulsing}, 1);
    wordsToSend = words;
    holdCredits = hold;
    acqHighCnt = 0;
    sro1Cnt = 0;
    sro2Cnt = 0;
    onceCnt = 0;
    checkPowerHigh = !pulsing;
    sendCmd(CmdStartAcq, n, 1);
    while (!START_ACQ) @(negedge Clk);
    sendCmd(CmdSetChannel, {15'h0, !chan}, 0);  // Rejected while acquiring
    while (!onceEnd) @(negedge Clk);
    repeat (2) @(negedge Clk);
    if (pulsing)
      assert ({PWR_ON_A, PWR_ON_D, PWR_ON_DAC, PWR_ON_ADC} == 4'h0)
        else reportMismatch("PWR_ON after onceEnd",
          {PWR_ON_A, PWR_ON_D, PWR_ON_DAC, PWR_ON_ADC}, 0);
    checkPowerHigh = 0;
    holdCredits = 0;  // Release the withheld burst
    while (expQ.size() != 0 || owed != 0) @(negedge Clk);
    assert (acqHighCnt == n) else reportMismatch("START_ACQ cycles", acqHighCnt, n);
    if (pulsing)
      assert (acqRiseCycle - pwrRiseCycle == 1)
        else reportMismatch("PWR_ON to START_ACQ", acqRiseCycle - pwrRiseCycle, 1);
    assert (sro1Cnt == !chan) else reportMismatch("START_READOUT1 pulses", sro1Cnt, !chan);
    assert (sro2Cnt == chan) else reportMismatch("START_READOUT2 pulses", sro2Cnt, chan);
    assert (onceCnt == 1) else reportMismatch("onceEnd pulses", onceCnt, 1);
    assert (overrun == 1'b0) else reportMismatch("overrun", overrun, 0);
  endtask

  initial begin
    void'($urandom(32'h1360));
    rstN <= 1'b0;
    hostCmd <= '0;
    scConfig <= '0;
    repeat (4) @(posedge Clk);
    rstN <= 1'b1;
    @(negedge Clk);
    // Inactive outputs after reset
    assert ({SR_RSTB, SR_CK, START_ACQ, RESET_B, START_READOUT1, START_READOUT2,
             fifoOut.valid, cmdAccept, cmdReject, loadDone, onceEnd, overrun} == 12'b000100000000)
      else reportMismatch("reset outputs", {SR_RSTB, SR_CK, START_ACQ, RESET_B, START_READOUT1,
        START_READOUT2, fifoOut.valid, cmdAccept, cmdReject, loadDone, onceEnd, overrun},
        12'b000100000000);
    loadConfig();
    loadConfig();
    runAcq(16'(8 + $urandom % 12), 1'b0, 1'b0, 3, 1'b0);
    runAcq(16'(5 + $urandom % 12), 1'b1, 1'b1, MaxWords, 1'b1);  // Credits withheld
    runAcq(16'd1, 1'b0, 1'b1, 2, 1'b0);
    repeat (10) @(posedge Clk);
    if (i_microrocControl.u_assertions.errCount == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      failNow("Bound concurrent assertions recorded failures");
    end
  end

endmodule

// File: microrocControl.f
design/microrocPkg.sv
design/commandDecode.sv
design/slowControlLoad.sv
design/daqSequencer.sv
design/ramReadout.sv
design/microrocControl.sv
verif/tbClock.sv
verif/microrocControlAssertions.sv
verif/microrocControlTb.sv
